/* lsu_top.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_ctrl.sv
src/wait_timer.sv
src/store_merge.sv
src/data_ram.sv
src/load_align.sv
src/lsu_top.sv
test/lsu_assertions.sv
test/lsu_tb.sv

/* Makefile */
# Verilator build and run of the lsu testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f lsu_top.f --top-module lsu_tb -o Vlsu_tb

run: build
	@out=$$(./obj_dir/Vlsu_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only +incdir+src src/lsu_pkg.sv src/lsu_ctrl.sv src/wait_timer.sv \
		src/store_merge.sv src/data_ram.sv src/load_align.sv src/lsu_top.sv \
		--top-module lsu_top

clean:
	rm -rf obj_dir

/* test/lsu_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lsu testbench with a table, a lane sweep, a busy drop and random accesses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lsu_cfg.svh"

module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    typedef struct packed {
        logic   we;
        width_t width;
        logic   uns;
        addr_t  addr;
        xlen_t  wdata;
        xlen_t  exp_rdata;
        fault_t exp_fault;
    } entry_t;

    localparam addr_t base = `LSU_RAM_BASE;
    // table, sweep, busy test, fill and random phase
    localparam int accesses = 300;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic req = 1'b0;
    logic we = 1'b0;
    width_t width = '0;
    logic is_unsigned = 1'b0;
    addr_t addr = '0;
    xlen_t wdata = '0;
    logic busy;
    logic done;
    logic fault;
    fault_t fault_code;
    xlen_t rdata;

    entry_t table_q[$];
    logic [7:0] shadow [4096];
    xlen_t last_rdata = '0;
    logic [31:0] seed = 32'h8ec9_ceba;
    int errors = 0;
    int tests = 0;

    lsu_top lsu_top_i (.*);

    always #50 clk = !clk;

    initial begin
        #((accesses * 10 + 10) * 100);
        $display("Timeout: run did not finish in time");
        $display("Errors found");
        $finish;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // expected load value from the byte model
    function automatic xlen_t predict_load(addr_t a, width_t w, logic uns);
        int off;
        int n;
        xlen_t v;
        off = int'(a - base);
        n = 1 << w;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < n) begin
                v[i*8 +: 8] = shadow[off + i];
            end else if (!uns && shadow[off + n - 1][7]) begin
                v[i*8 +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    task automatic check_value(string name, xlen_t got, xlen_t exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic add_entry(logic w, width_t wd, logic u, addr_t a, xlen_t d, xlen_t r,
                             fault_t f);
        table_q.push_back('{w, wd, u, a, d, r, f});
    endtask

    task automatic do_access(string name, logic w, width_t wd, logic u, addr_t a, xlen_t d,
                             xlen_t exp_rdata, fault_t exp_fault);
        int cycles;
        int errors_before;
        cycles = 0;
        errors_before = errors;
        @(posedge clk);
        #5;
        req = 1'b1;
        we = w;
        width = wd;
        is_unsigned = u;
        addr = a;
        wdata = d;
        @(posedge clk);
        #5;
        req = 1'b0;
        while (!(done || fault) && cycles < 20) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        if (exp_fault == fault_none) begin
            assert (done && !fault) else begin
                $display("%s: access did not end with done", name);
                errors++;
            end
            check_value("done cycle", xlen_t'(cycles), xlen_t'(`LSU_WAIT_STATES + 3));
            if (!w) begin
                last_rdata = exp_rdata;
            end else begin
                for (int i = 0; i < (1 << wd); i++) begin
                    shadow[int'(a - base) + i] = d[i*8 +: 8];
                end
            end
        end else begin
            assert (fault && !done) else begin
                $display("%s: access did not end with a fault", name);
                errors++;
            end
            check_value("fault cycle", xlen_t'(cycles), 64'd0);
            check_value("fault_code", xlen_t'(fault_code), xlen_t'(exp_fault));
        end
        check_value("rdata", rdata, exp_rdata);
        tests++;
        $display("test %0d %s: %s", tests, name, errors == errors_before ? "ok" : "FAILED");
    endtask

    // a second req while busy must be dropped
    task automatic busy_drop_test();
        int cycles;
        int errors_before;
        cycles = 0;
        errors_before = errors;
        @(posedge clk);
        #5;
        req = 1'b1;
        we = 1'b1;
        width = `LSU_WDT_64;
        addr = base + 32'h40;
        wdata = 64'h1122_3344_5566_7788;
        @(posedge clk);
        #5;
        req = 1'b0;
        @(posedge clk);
        #5;
        req = 1'b1;
        addr = base + 32'h48;
        wdata = 64'hdead_beef_dead_beef;
        check_value("busy", xlen_t'(busy), 64'd1);
        @(posedge clk);
        #5;
        req = 1'b0;
        while (!done && cycles < 20) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        assert (done) else begin
            $display("busy drop: first access never completed");
            errors++;
        end
        for (int i = 0; i < 8; i++) begin
            shadow[32'h40 + i] = 8'(64'h1122_3344_5566_7788 >> (i * 8));
        end
        tests++;
        $display("test %0d busy drop: %s", tests, errors == errors_before ? "ok" : "FAILED");
    endtask

    initial begin
        entry_t e;
        logic [31:0] r;
        addr_t a;
        width_t wd;
        xlen_t d;
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;
        check_value("rdata", rdata, '0);
        check_value("busy", xlen_t'(busy), '0);
        check_value("done", xlen_t'(done), '0);
        check_value("fault", xlen_t'(fault), '0);
        check_value("fault_code", xlen_t'(fault_code), '0);
        tests++;
        $display("test %0d reset values: %s", tests, errors == 0 ? "ok" : "FAILED");

        // full store and load, narrow merges, signed and unsigned lanes, faults
        add_entry(1, `LSU_WDT_64, 0, base + 32'h10, 64'h0123_4567_89ab_cdef, 64'h0, 0);
        add_entry(0, `LSU_WDT_64, 0, base + 32'h10, 0, 64'h0123_4567_89ab_cdef, 0);
        add_entry(1, `LSU_WDT_8, 0, base + 32'h11, 64'hffff_ffff_ffff_ff5a,
                  64'h0123_4567_89ab_cdef, 0);
        add_entry(1, `LSU_WDT_16, 0, base + 32'h16, 64'h1111_2222_3333_beef,
                  64'h0123_4567_89ab_cdef, 0);
        add_entry(0, `LSU_WDT_64, 0, base + 32'h10, 0, 64'hbeef_4567_89ab_5aef, 0);
        add_entry(1, `LSU_WDT_64, 0, base + 32'h20, 64'hf8e7_d6c5_b4a3_9281,
                  64'hbeef_4567_89ab_5aef, 0);
        add_entry(0, `LSU_WDT_8, 0, base + 32'h23, 0, 64'hffff_ffff_ffff_ffb4, 0);
        add_entry(0, `LSU_WDT_8, 1, base + 32'h23, 0, 64'h0000_0000_0000_00b4, 0);
        add_entry(0, `LSU_WDT_16, 0, base + 32'h26, 0, 64'hffff_ffff_ffff_f8e7, 0);
        add_entry(0, `LSU_WDT_16, 1, base + 32'h26, 0, 64'h0000_0000_0000_f8e7, 0);
        add_entry(0, `LSU_WDT_32, 0, base + 32'h24, 0, 64'hffff_ffff_f8e7_d6c5, 0);
        add_entry(0, `LSU_WDT_32, 1, base + 32'h24, 0, 64'h0000_0000_f8e7_d6c5, 0);
        add_entry(0, `LSU_WDT_16, 0, base + 32'h21, 0, 64'h0000_0000_f8e7_d6c5, 1);
        add_entry(1, `LSU_WDT_32, 0, base + 32'h22, 64'h0, 64'h0000_0000_f8e7_d6c5, 1);
        add_entry(0, `LSU_WDT_64, 0, base + 32'h24, 0, 64'h0000_0000_f8e7_d6c5, 1);
        add_entry(0, `LSU_WDT_8, 0, 32'h7fff_ffff, 0, 64'h0000_0000_f8e7_d6c5, 2);
        add_entry(1, `LSU_WDT_64, 0, base + 32'h1000, 64'h0, 64'h0000_0000_f8e7_d6c5, 2);
        add_entry(0, `LSU_WDT_64, 0, 32'h9000_0001, 0, 64'h0000_0000_f8e7_d6c5, 1);
        add_entry(0, `LSU_WDT_64, 0, base + 32'h20, 0, 64'hf8e7_d6c5_b4a3_9281, 0);
        foreach (table_q[i]) begin
            e = table_q[i];
            do_access("table", e.we, e.width, e.uns, e.addr, e.wdata, e.exp_rdata,
                      e.exp_fault);
        end

        // every lane at each narrow width with both extensions
        for (int w = 0; w < 3; w++) begin
            for (int l = 0; l < 8; l += (1 << w)) begin
                for (int u = 0; u < 2; u++) begin
                    a = base + 32'h20 + addr_t'(l);
                    do_access("lane sweep", 0, width_t'(w), u[0], a, 0,
                              predict_load(a, width_t'(w), u[0]), 0);
                end
            end
        end

        do_access("busy setup", 1, `LSU_WDT_64, 0, base + 32'h48, 64'h0f0f_0f0f_f0f0_f0f0,
                  last_rdata, 0);
        busy_drop_test();
        do_access("busy check", 0, `LSU_WDT_64, 0, base + 32'h48, 0,
                  predict_load(base + 32'h48, `LSU_WDT_64, 0), 0);
        do_access("busy check", 0, `LSU_WDT_64, 0, base + 32'h40, 0,
                  predict_load(base + 32'h40, `LSU_WDT_64, 0), 0);

        // random region at offset 800 hex is filled from its own addresses
        for (int i = 0; i < 32; i++) begin
            a = base + 32'h800 + addr_t'(i * 8);
            do_access("fill", 1, `LSU_WDT_64, 0, a, {~a, a}, last_rdata, 0);
        end
        for (int i = 0; i < 200; i++) begin
            r = next_random();
            wd = r[2:1];
            a = base + 32'h800 + addr_t'({r[8:4], 3'b000})
                + addr_t'(r[13:11] & ~3'((1 << wd) - 1));
            d = {next_random(), next_random()};
            if (r[0]) begin
                do_access("random store", 1, wd, r[3], a, d, last_rdata, 0);
            end else begin
                do_access("random load", 0, wd, r[3], a, 0, predict_load(a, wd, r[3]), 0);
            end
        end

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* test/lsu_assertions.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lsu protocol assertions on the done, fault and busy strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lsu_cfg.svh"

module lsu_assertions (
    input logic clk,
    input logic reset,
    input logic req,
    input logic busy,
    input logic done,
    input logic fault
);
    timeunit 1ns;
    timeprecision 100ps;

    // one outcome per access
    done_fault_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(done && fault)) else $error("done and fault high together");

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done) else $error("done longer than one cycle");

    fault_one_cycle: assert property (@(posedge clk) disable iff (reset)
        fault |=> !fault) else $error("fault longer than one cycle");

    busy_release: assert property (@(posedge clk) disable iff (reset)
        (done || fault) |=> !busy) else $error("busy still high after done or fault");

    // valid access latency counted from the accepting edge
    done_latency: assert property (@(posedge clk) disable iff (reset)
        (req && !busy) ##1 !fault |-> ##(`LSU_WAIT_STATES + 3) done)
        else $error("done not at the expected cycle");

endmodule

bind lsu_top lsu_assertions assertions_i (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .busy  (busy),
    .done  (done),
    .fault (fault)
);

/* src/lsu_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store unit top: controller, wait timer, store merge, RAM, load align
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lsu_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            req,
    input  logic            we,
    input  lsu_pkg::width_t width,
    input  logic            is_unsigned,
    input  lsu_pkg::addr_t  addr,
    input  lsu_pkg::xlen_t  wdata,
    output logic            busy,
    output logic            done,
    output logic            fault,
    output lsu_pkg::fault_t fault_code,
    output lsu_pkg::xlen_t  rdata
);
    import lsu_pkg::*;

    logic     start;
    logic     load;
    logic     expired;
    logic     ram_en;
    logic     ram_we;
    logic     load_done;
    logic     acc_unsigned;
    index_t   index;
    lane_t    lane;
    width_t   acc_width;
    byte_en_t byte_en;
    xlen_t    wword;
    xlen_t    rword;

    lsu_ctrl ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .we           (we),
        .width        (width),
        .is_unsigned  (is_unsigned),
        .addr         (addr),
        .expired      (expired),
        .start        (start),
        .load         (load),
        .ram_en       (ram_en),
        .ram_we       (ram_we),
        .index        (index),
        .lane         (lane),
        .acc_width    (acc_width),
        .acc_unsigned (acc_unsigned),
        .busy         (busy),
        .done         (done),
        .load_done    (load_done),
        .fault        (fault),
        .fault_code   (fault_code)
    );

    wait_timer timer_i (
        .clk     (clk),
        .reset   (reset),
        .load    (load),
        .expired (expired)
    );

    store_merge merge_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .wdata     (wdata),
        .lane      (lane),
        .acc_width (acc_width),
        .byte_en   (byte_en),
        .wword     (wword)
    );

    data_ram ram_i (
        .clk     (clk),
        .ram_en  (ram_en),
        .ram_we  (ram_we),
        .index   (index),
        .byte_en (byte_en),
        .wword   (wword),
        .rword   (rword)
    );

    load_align align_i (
        .clk          (clk),
        .reset        (reset),
        .load_done    (load_done),
        .rword        (rword),
        .lane         (lane),
        .acc_width    (acc_width),
        .acc_unsigned (acc_unsigned),
        .rdata        (rdata)
    );

endmodule

/* src/load_align.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load align: selects the addressed lane and extends it to 64 bits
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lsu_cfg.svh"

module load_align (
    input  logic            clk,
    input  logic            reset,
    input  logic            load_done,
    input  lsu_pkg::xlen_t  rword,
    input  lsu_pkg::lane_t  lane,
    input  lsu_pkg::width_t acc_width,
    input  logic            acc_unsigned,
    output lsu_pkg::xlen_t  rdata
);
    import lsu_pkg::*;

    xlen_t shifted;
    xlen_t aligned;
    xlen_t held;

    // addressed byte moved down to bit 0
    assign shifted = rword >> {lane, 3'b000};

    always_comb begin
        case (acc_width)
            `LSU_WDT_8: begin
                aligned = acc_unsigned ? {56'b0, shifted[7:0]}
                                       : {{56{shifted[7]}}, shifted[7:0]};
            end
            `LSU_WDT_16: begin
                aligned = acc_unsigned ? {48'b0, shifted[15:0]}
                                       : {{48{shifted[15]}}, shifted[15:0]};
            end
            `LSU_WDT_32: begin
                aligned = acc_unsigned ? {32'b0, shifted[31:0]}
                                       : {{32{shifted[31]}}, shifted[31:0]};
            end
            default: aligned = shifted;
        endcase
    end

    // last load result, kept across stores and faults
    always_ff @(posedge clk) begin
        if (reset) begin
            held <= '0;
        end else if (load_done) begin
            held <= aligned;
        end
    end

    // fresh word shows already in the finish cycle
    assign rdata = load_done ? aligned : held;

endmodule

/* src/data_ram.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data RAM: doubleword array with byte write enables and registered read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lsu_cfg.svh"

module data_ram (
    input  logic              clk,
    input  logic              ram_en,
    input  logic              ram_we,
    input  lsu_pkg::index_t   index,
    input  lsu_pkg::byte_en_t byte_en,
    input  lsu_pkg::xlen_t    wword,
    output lsu_pkg::xlen_t    rword
);
    import lsu_pkg::*;

    xlen_t mem [`LSU_RAM_WORDS];

    // write
    always_ff @(posedge clk) begin
        if (ram_en && ram_we) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_en[b]) begin
                    mem[index][b*8 +: 8] <= wword[b*8 +: 8];
                end
            end
        end
    end

    // read, valid the cycle after ram_en
    always_ff @(posedge clk) begin
        if (ram_en && !ram_we) begin
            rword <= mem[index];
        end
    end

endmodule

/* src/store_merge.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store merge: holds store data and places it on its byte lanes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lsu_cfg.svh"

module store_merge (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  lsu_pkg::xlen_t    wdata,
    input  lsu_pkg::lane_t    lane,
    input  lsu_pkg::width_t   acc_width,
    output lsu_pkg::byte_en_t byte_en,
    output lsu_pkg::xlen_t    wword
);
    import lsu_pkg::*;

    xlen_t    data_q;
    byte_en_t pattern;

    // taken in the accept cycle while wdata is still driven
    always_ff @(posedge clk) begin
        if (reset) begin
            data_q <= '0;
        end else if (start) begin
            data_q <= wdata;
        end
    end

    // bytes covered at lane 0
    always_comb begin
        case (acc_width)
            `LSU_WDT_8:  pattern = 8'h01;
            `LSU_WDT_16: pattern = 8'h03;
            `LSU_WDT_32: pattern = 8'h0f;
            default:     pattern = 8'hff;
        endcase
    end

    // alignment is checked upstream, so nothing shifts out of the word
    assign byte_en = pattern << lane;

    // bytes above the width land on disabled lanes
    assign wword = data_q << {lane, 3'b000};

endmodule

/* src/wait_timer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wait-state timer: counts down the RAM wait cycles after a load pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lsu_cfg.svh"

module wait_timer (
    input  logic clk,
    input  logic reset,
    input  logic load,
    output logic expired
);

    // wide enough for the count, at least one bit even with no wait states
    localparam int count_bits = $clog2(`LSU_WAIT_STATES + 2);

    logic [count_bits-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= count_bits'(`LSU_WAIT_STATES);
        end else if (count != '0) begin
            count <= count - count_bits'(1);
        end
    end

    // stays up at zero until reloaded
    assign expired = count == '0;

endmodule

/* src/lsu_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lsu controller: captures and checks a request, then runs the RAM access
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lsu_cfg.svh"

module lsu_ctrl (
    input  logic            clk,
    input  logic            reset,
    input  logic            req,
    input  logic            we,
    input  lsu_pkg::width_t width,
    input  logic            is_unsigned,
    input  lsu_pkg::addr_t  addr,
    input  logic            expired,
    output logic            start,
    output logic            load,
    output logic            ram_en,
    output logic            ram_we,
    output lsu_pkg::index_t index,
    output lsu_pkg::lane_t  lane,
    output lsu_pkg::width_t acc_width,
    output logic            acc_unsigned,
    output logic            busy,
    output logic            done,
    output logic            load_done,
    output logic            fault,
    output lsu_pkg::fault_t fault_code
);
    import lsu_pkg::*;

    localparam addr_t ram_bytes = addr_t'(`LSU_RAM_WORDS * 8);

    lsu_state_t state;
    logic       we_q;
    addr_t      addr_q;
    // high in the cycle right after acceptance
    logic       first;
    addr_t      offset;
    logic       misaligned;
    fault_t     check_code;

    // req only counts while idle
    assign start = req && (state == idle);
    assign busy  = state != idle;

    // below the base wraps to a large offset, so one compare covers both ends
    assign offset = addr_q - `LSU_RAM_BASE;

    always_comb begin
        case (acc_width)
            `LSU_WDT_16: misaligned = addr_q[0];
            `LSU_WDT_32: misaligned = |addr_q[1:0];
            `LSU_WDT_64: misaligned = |addr_q[2:0];
            default:     misaligned = 1'b0;
        endcase
    end

    // misalignment wins over the window check
    assign check_code = misaligned ? fault_misaligned :
                        (offset >= ram_bytes) ? fault_window : fault_none;

    assign fault      = first && (check_code != fault_none);
    assign fault_code = first ? check_code : fault_none;
    assign load       = first && !fault;

    assign ram_en    = state == access;
    assign ram_we    = ram_en && we_q;
    assign done      = state == finish;
    assign load_done = done && !we_q;

    assign index = offset[`LSU_INDEX_BITS+2:3];
    assign lane  = addr_q[2:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            first <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            first <= start;
            if (start) begin
                we_q <= we;
            end
            case (state)
                idle: begin
                    if (start) begin
                        state <= wait_ram;
                    end
                end
                wait_ram: begin
                    // expired is stale from the last access until the timer reloads
                    if (fault) begin
                        state <= idle;
                    end else if (!first && expired) begin
                        state <= access;
                    end
                end
                access:  state <= finish;
                finish:  state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q       <= addr;
            acc_width    <= width;
            acc_unsigned <= is_unsigned;
        end
    end

endmodule

/* src/lsu_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lsu types: data and address words, RAM indexing, fault codes, FSM states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "lsu_cfg.svh"

package lsu_pkg;

    // register width of the core
    typedef logic [63:0] xlen_t;

    // byte address as seen on the data side
    typedef logic [31:0] addr_t;

    // doubleword index into the RAM
    typedef logic [`LSU_INDEX_BITS-1:0] index_t;

    // byte offset inside a doubleword
    typedef logic [2:0] lane_t;

    // one enable per byte of a doubleword
    typedef logic [7:0] byte_en_t;

    // access width, one of the LSU_WDT codes
    typedef logic [1:0] width_t;

    typedef logic [1:0] fault_t;

    localparam fault_t fault_none       = 2'd0;
    localparam fault_t fault_misaligned = 2'd1;
    localparam fault_t fault_window     = 2'd2;

    // controller states
    typedef enum logic [1:0] {
        idle,
        wait_ram,
        access,
        finish
    } lsu_state_t;

endpackage

/* src/lsu_cfg.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lsu configuration: RAM window, depth, wait states and access width codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// first byte address of the data RAM
`define LSU_RAM_BASE 32'h8000_0000

// 512 doublewords, 4 KiB in total
`define LSU_RAM_WORDS 512

// bits needed to index one doubleword
`define LSU_INDEX_BITS 9

// extra cycles spent before the RAM cycle
`define LSU_WAIT_STATES 2

// access width codes, as in funct3[1:0] of loads and stores
`define LSU_WDT_8  2'd0
`define LSU_WDT_16 2'd1
`define LSU_WDT_32 2'd2
`define LSU_WDT_64 2'd3

`endif
